//--- hdl/ooo_defs.svh
// core size parameters

`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath width
`define XLEN 32

// architectural register count
`define NUM_REGS 32

// rob entries, keep a power of two so tags wrap cleanly
`define ROB_DEPTH 8

// alu station entries
`define RS_DEPTH 4

`endif

//--- hdl/isa_pkg.sv
// rv32i instruction set types

`include "ooo_defs.svh"

package isa_pkg;

	// basic vectors
	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
	typedef logic [31:0] inst_t;

	// major opcodes handled by the alu path
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_t;

	// alu functions
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	// funct3 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 codes for register-register ops
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- hdl/core_pkg.sv
// out-of-order core types

`include "ooo_defs.svh"

package core_pkg;

	import isa_pkg::*;

	// rob slot index, doubles as the producer tag
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// source operand, either a value or a pending tag
	typedef struct packed {
		logic     ready;
		word_t    value;
		rob_tag_t tag;
	} operand_t;

	// one instruction leaving issue
	typedef struct packed {
		logic     valid;
		alu_op_t  alu_op;
		operand_t src1;
		operand_t src2;
		rob_tag_t dest_tag;
		reg_idx_t rd;
		logic     wr_en;
	} issue_pkt_t;

	// common data bus
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    value;
	} cdb_t;

	// retirement packet from rob head
	typedef struct packed {
		logic     valid;
		logic     wr_en;
		reg_idx_t rd;
		word_t    value;
	} commit_t;

endpackage

//--- hdl/issue_stage.sv
// instruction issue stage

`timescale 1ns/1ps
`include "ooo_defs.svh"

module issue_stage
	import isa_pkg::*, core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       inst_req,
	input  inst_t      inst,
	output logic       inst_ack,
	input  logic       rob_full,
	input  logic       rs_full,
	input  rob_tag_t   alloc_tag,
	input  operand_t   rob_read_rs1,
	input  operand_t   rob_read_rs2,
	output rob_tag_t   read_tag_rs1,
	output rob_tag_t   read_tag_rs2,
	input  cdb_t       cdb,
	input  commit_t    commit,
	output issue_pkt_t issue
);

	typedef enum logic {HS_WAIT, HS_ACK} hs_state_t;

	hs_state_t state, state_next;
	logic alloc;

	// decode fields
	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rs1, rs2, rd;
	word_t imm;
	alu_op_t alu_op;
	logic supported, is_imm;

	// architectural state
	word_t regfile [`NUM_REGS];
	logic [`NUM_REGS-1:0] map_valid;
	rob_tag_t map_tag [`NUM_REGS];
	// follows rob head, commits retire in tag order
	rob_tag_t commit_tag;

	// value / rob / cdb / tag priority
	function automatic operand_t resolve(input reg_idx_t idx, input logic mapped,
			input operand_t rob_op, input cdb_t bus, input word_t rf_value);
		operand_t op;
		op.ready = 1'b1;
		op.value = '0;
		op.tag = rob_op.tag;
		if (idx == '0) begin
			op.value = '0;
		end else if (!mapped) begin
			op.value = rf_value;
		end else if (rob_op.ready) begin
			op.value = rob_op.value;
		end else if (bus.valid && bus.tag == rob_op.tag) begin
			op.value = bus.value;
		end else begin
			op.ready = 1'b0;
		end
		return op;
	endfunction

	////////////////////////////////
	// handshake
	////////////////////////////////

	// accept only while idle with room in both rob and station
	assign alloc = (state == HS_WAIT) && inst_req && !rob_full && !rs_full;
	assign inst_ack = (state == HS_ACK);

	always_comb begin
		state_next = state;
		case (state)
			HS_WAIT: if (alloc) state_next = HS_ACK;
			HS_ACK:  if (!inst_req) state_next = HS_WAIT;
			default: state_next = HS_WAIT;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= HS_WAIT;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////
	// decode
	////////////////////////////////

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};

	always_comb begin
		alu_op = ALU_ADD;
		supported = 1'b0;
		is_imm = 1'b0;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				is_imm = (opcode == OPC_OP_IMM);
				supported = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = (!is_imm && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					default:    supported = 1'b0;
				endcase
				// register ops only allow the base funct7, or sub on funct3 0
				if (!is_imm && funct7 != F7_BASE &&
						!(funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
					supported = 1'b0;
				end
			end
			default: supported = 1'b0;
		endcase
	end

	////////////////////////////////
	// operand lookup
	////////////////////////////////

	assign read_tag_rs1 = map_tag[rs1];
	assign read_tag_rs2 = map_tag[rs2];

	always_comb begin
		issue.valid = alloc;
		issue.alu_op = alu_op;
		issue.src1 = resolve(rs1, map_valid[rs1], rob_read_rs1, cdb, regfile[rs1]);
		if (is_imm) begin
			issue.src2.ready = 1'b1;
			issue.src2.value = imm;
			issue.src2.tag = '0;
		end else begin
			issue.src2 = resolve(rs2, map_valid[rs2], rob_read_rs2, cdb, regfile[rs2]);
		end
		issue.dest_tag = alloc_tag;
		issue.rd = rd;
		// unsupported encodings still retire, just no write
		issue.wr_en = supported && (rd != '0);
	end

	// register file, map table, commit tracking
	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
			commit_tag <= '0;
			for (int i = 0; i < `NUM_REGS; i++) begin
				regfile[i] <= '0;
			end
		end else begin
			if (commit.valid) begin
				commit_tag <= commit_tag + 1'b1;
				if (commit.wr_en && commit.rd != '0) begin
					regfile[commit.rd] <= commit.value;
				end
				// only clear if no younger writer took the entry
				if (map_valid[commit.rd] && map_tag[commit.rd] == commit_tag) begin
					map_valid[commit.rd] <= 1'b0;
				end
			end
			// new mapping wins over a same-cycle clear
			if (issue.valid && issue.wr_en) begin
				map_valid[issue.rd] <= 1'b1;
				map_tag[issue.rd] <= alloc_tag;
			end
		end
	end

endmodule

//--- hdl/reorder_buffer.sv
// reorder buffer

`timescale 1ns/1ps
`include "ooo_defs.svh"

module reorder_buffer
	import isa_pkg::*, core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  issue_pkt_t issue,
	output rob_tag_t   alloc_tag,
	output logic       full,
	input  rob_tag_t   read_tag_rs1,
	input  rob_tag_t   read_tag_rs2,
	output operand_t   rob_read_rs1,
	output operand_t   rob_read_rs2,
	input  cdb_t       cdb,
	output commit_t    commit
);

	localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

	// entry control
	logic [`ROB_DEPTH-1:0] busy;
	logic [`ROB_DEPTH-1:0] done;
	// entry payload
	logic [`ROB_DEPTH-1:0] wr_en;
	reg_idx_t rd [`ROB_DEPTH];
	word_t value [`ROB_DEPTH];

	rob_tag_t head, tail;
	logic [CNT_W-1:0] count;

	assign alloc_tag = tail;
	assign full = (count == CNT_W'(`ROB_DEPTH));

	////////////////////////////////
	// read ports
	////////////////////////////////

	// completed entries forward their value to issue
	assign rob_read_rs1.ready = busy[read_tag_rs1] && done[read_tag_rs1];
	assign rob_read_rs1.value = value[read_tag_rs1];
	assign rob_read_rs1.tag = read_tag_rs1;

	assign rob_read_rs2.ready = busy[read_tag_rs2] && done[read_tag_rs2];
	assign rob_read_rs2.value = value[read_tag_rs2];
	assign rob_read_rs2.tag = read_tag_rs2;

	////////////////////////////////
	// commit
	////////////////////////////////

	// head retires as soon as it completes
	assign commit.valid = busy[head] && done[head];
	assign commit.wr_en = wr_en[head];
	assign commit.rd = rd[head];
	assign commit.value = value[head];

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			busy <= '0;
			done <= '0;
		end else begin
			if (commit.valid) begin
				busy[head] <= 1'b0;
				head <= head + 1'b1;
			end
			if (issue.valid) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// result capture, tag never equals the slot being allocated
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
			case ({issue.valid, commit.valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (issue.valid) begin
			wr_en[tail] <= issue.wr_en;
			rd[tail] <= issue.rd;
		end
		if (cdb.valid) begin
			value[cdb.tag] <= cdb.value;
		end
	end

endmodule

//--- hdl/reservation_station.sv
// alu reservation station

`timescale 1ns/1ps
`include "ooo_defs.svh"

module reservation_station
	import isa_pkg::*, core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  issue_pkt_t issue,
	input  cdb_t       cdb,
	output logic       full,
	output issue_pkt_t dispatch
);

	localparam int SEL_W = $clog2(`RS_DEPTH);

	issue_pkt_t entries [`RS_DEPTH];
	// entries after insert and cdb capture, this cycle
	issue_pkt_t view [`RS_DEPTH];
	logic [`RS_DEPTH-1:0] busy;
	logic [`RS_DEPTH-1:0] ready_vec;
	logic [SEL_W-1:0] sel;
	logic any_ready;
	logic placed;

	// wake a waiting operand on matching broadcast
	function automatic operand_t snoop(input operand_t op, input cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	////////////////////////////////
	// insert and wakeup
	////////////////////////////////

	always_comb begin
		placed = 1'b0;
		for (int i = 0; i < `RS_DEPTH; i++) begin
			busy[i] = entries[i].valid;
			view[i] = entries[i];
			// new instruction goes into the first free slot
			if (!entries[i].valid && issue.valid && !placed) begin
				view[i] = issue;
				placed = 1'b1;
			end
			view[i].src1 = snoop(view[i].src1, cdb);
			view[i].src2 = snoop(view[i].src2, cdb);
			ready_vec[i] = view[i].valid && view[i].src1.ready && view[i].src2.ready;
		end
	end

	assign full = &busy;

	////////////////////////////////
	// select
	////////////////////////////////

	// lowest index wins, scan from the top down
	always_comb begin
		sel = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (ready_vec[i]) begin
				sel = SEL_W'(i);
			end
		end
	end

	assign any_ready = |ready_vec;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				entries[i].valid <= 1'b0;
			end
			dispatch.valid <= 1'b0;
		end else begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				entries[i] <= view[i];
				// selected entry leaves the station
				if (any_ready && sel == SEL_W'(i)) begin
					entries[i].valid <= 1'b0;
				end
			end
			dispatch <= view[sel];
			dispatch.valid <= any_ready;
		end
	end

endmodule

//--- hdl/alu_unit.sv
// alu execution unit

`timescale 1ns/1ps

module alu_unit
	import isa_pkg::*, core_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  issue_pkt_t dispatch,
	output cdb_t       cdb
);

	word_t a, b, result;

	assign a = dispatch.src1.value;
	assign b = dispatch.src2.value;

	always_comb begin
		case (dispatch.alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			default: result = a + b;
		endcase
	end

	////////////////////////////////
	// cdb register
	////////////////////////////////

	// single producer, broadcast the cycle after dispatch
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= dispatch.valid;
			cdb.tag <= dispatch.dest_tag;
			cdb.value <= result;
		end
	end

endmodule

//--- hdl/ooo_core.sv
// out-of-order core top

`timescale 1ns/1ps

module ooo_core
	import isa_pkg::*, core_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    inst_req,
	input  inst_t   inst,
	output logic    inst_ack,
	output commit_t commit
);

	// issue to rob and station
	issue_pkt_t issue;
	rob_tag_t alloc_tag;
	logic rob_full, rs_full;
	// rob operand read ports
	rob_tag_t read_tag_rs1, read_tag_rs2;
	operand_t rob_read_rs1, rob_read_rs2;
	// execute and broadcast
	issue_pkt_t dispatch;
	cdb_t cdb;

	////////////////////////////////
	// issue
	////////////////////////////////

	issue_stage issue_stage_inst (
		.clock        (clock),
		.reset        (reset),
		.inst_req     (inst_req),
		.inst         (inst),
		.inst_ack     (inst_ack),
		.rob_full     (rob_full),
		.rs_full      (rs_full),
		.alloc_tag    (alloc_tag),
		.rob_read_rs1 (rob_read_rs1),
		.rob_read_rs2 (rob_read_rs2),
		.read_tag_rs1 (read_tag_rs1),
		.read_tag_rs2 (read_tag_rs2),
		.cdb          (cdb),
		.commit       (commit),
		.issue        (issue)
	);

	// rob, also the commit source
	reorder_buffer reorder_buffer_inst (
		.clock        (clock),
		.reset        (reset),
		.issue        (issue),
		.alloc_tag    (alloc_tag),
		.full         (rob_full),
		.read_tag_rs1 (read_tag_rs1),
		.read_tag_rs2 (read_tag_rs2),
		.rob_read_rs1 (rob_read_rs1),
		.rob_read_rs2 (rob_read_rs2),
		.cdb          (cdb),
		.commit       (commit)
	);

	////////////////////////////////
	// execute
	////////////////////////////////

	reservation_station reservation_station_inst (
		.clock    (clock),
		.reset    (reset),
		.issue    (issue),
		.cdb      (cdb),
		.full     (rs_full),
		.dispatch (dispatch)
	);

	alu_unit alu_unit_inst (
		.clock    (clock),
		.reset    (reset),
		.dispatch (dispatch),
		.cdb      (cdb)
	);

endmodule

//--- bench/ooo_core_sva.sv
// core handshake assertions

`timescale 1ns/1ps

module ooo_core_sva (
	input logic clock,
	input logic reset,
	input logic inst_req,
	input logic inst_ack,
	input logic commit_valid
);

	// ack only answers a live request
	ack_rise_on_req: assert property (@(posedge clock) disable iff (reset)
		$rose(inst_ack) |-> $past(inst_req))
		else $error("inst_ack rose while inst_req was low");

	// ack held until the source lets go
	ack_fall_after_release: assert property (@(posedge clock) disable iff (reset)
		$fell(inst_ack) |-> !$past(inst_req))
		else $error("inst_ack fell while inst_req was still high");

	// quiet right out of reset
	reset_quiet: assert property (@(posedge clock) $past(reset) |-> !inst_ack && !commit_valid)
		else $error("inst_ack or commit valid active right after reset");

endmodule

bind ooo_core ooo_core_sva ooo_core_sva_inst (
	.clock        (clock),
	.reset        (reset),
	.inst_req     (inst_req),
	.inst_ack     (inst_ack),
	.commit_valid (commit.valid)
);

//--- bench/ooo_core_tb.sv
// out-of-order core testbench

`timescale 1ns/1ps
`include "ooo_defs.svh"

module ooo_core_tb
	import isa_pkg::*, core_pkg::*;
();

	localparam int MAX_ROWS = 64;

	logic clock = 1'b0;
	logic reset;
	logic inst_req;
	inst_t inst;
	logic inst_ack;
	commit_t commit;

	// stimulus table, expected is {wr_en, rd, value}
	string row_name [MAX_ROWS];
	inst_t row_inst [MAX_ROWS];
	int row_gap [MAX_ROWS];
	logic [37:0] row_expect [MAX_ROWS];
	int num_rows = 0;

	// golden register state
	word_t gold [32];

	int errors = 0;
	int err_before;
	int commit_count = 0;
	int ack_count = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	logic ack_prev = 1'b0;
	logic req_seen = 1'b0;

	ooo_core ooo_core_inst (
		.clock    (clock),
		.reset    (reset),
		.inst_req (inst_req),
		.inst     (inst),
		.inst_ack (inst_ack),
		.commit   (commit)
	);

	always #2 clock = ~clock;

	//////////////////////////////
	// encoders and golden model
	//////////////////////////////

	function automatic inst_t enc_imm(input logic [2:0] f3, input reg_idx_t rd,
			input reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic inst_t enc_reg(input logic [6:0] f7, input logic [2:0] f3,
			input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// run one instruction over the golden registers, append the row
	task automatic add_row(input string name, input inst_t code, input int gap);
		word_t a, b, res;
		logic [4:0] rd;
		rd = code[11:7];
		a = gold[code[19:15]];
		// bit 5 splits OP from OP-IMM
		b = code[5] ? gold[code[24:20]] : {{20{code[31]}}, code[31:20]};
		case (code[14:12])
			3'b000:  res = (code[5] && code[30]) ? a - b : a + b;
			3'b100:  res = a ^ b;
			3'b110:  res = a | b;
			default: res = a & b;
		endcase
		if (rd != 5'd0) begin
			gold[rd] = res;
		end
		row_name[num_rows] = name;
		row_inst[num_rows] = code;
		row_gap[num_rows] = gap;
		row_expect[num_rows] = {rd != 5'd0, rd, res};
		num_rows++;
	endtask

	task automatic build_table();
		int op_sel;
		logic [6:0] f7;
		logic [2:0] f3;
		// independent immediates and a register op
		add_row("addi_x1", enc_imm(3'b000, 5'd1, 5'd0, 12'd5), 2);
		add_row("addi_x2_neg", enc_imm(3'b000, 5'd2, 5'd0, 12'hffd), 1);
		add_row("xori_x3", enc_imm(3'b100, 5'd3, 5'd0, 12'h7ff), 0);
		add_row("ori_x4", enc_imm(3'b110, 5'd4, 5'd0, 12'h0f0), 0);
		add_row("add_x5", enc_reg(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), 0);
		// raw chain on x6, reused right away
		add_row("chain_addi", enc_imm(3'b000, 5'd6, 5'd0, 12'd1), 0);
		add_row("chain_add_a", enc_reg(7'h00, 3'b000, 5'd6, 5'd6, 5'd6), 0);
		add_row("chain_add_b", enc_reg(7'h00, 3'b000, 5'd6, 5'd6, 5'd6), 0);
		add_row("chain_andi", enc_imm(3'b111, 5'd7, 5'd6, 12'h00c), 0);
		add_row("chain_sub", enc_reg(7'h20, 3'b000, 5'd8, 5'd7, 5'd6), 0);
		// x0 writes, then reads of x0
		add_row("x0_addi", enc_imm(3'b000, 5'd0, 5'd1, 12'd9), 0);
		add_row("x0_add", enc_reg(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), 0);
		add_row("x0_read_or", enc_reg(7'h00, 3'b110, 5'd9, 5'd0, 5'd0), 0);
		add_row("x0_read_addi", enc_imm(3'b000, 5'd10, 5'd0, 12'd3), 0);
		// burst past rob depth, each reads the previous result
		for (int i = 0; i < `ROB_DEPTH + 4; i++) begin
			add_row($sformatf("burst_%0d", i), enc_imm(3'b000, reg_idx_t'(11 + i % 3),
				reg_idx_t'(11 + (i + 2) % 3), 12'(i + 1)), 0);
		end
		// random gaps, overlapping registers
		for (int i = 0; i < 12; i++) begin
			op_sel = int'($urandom % 4);
			f7 = (op_sel == 0) ? 7'h20 : 7'h00;
			case (op_sel)
				0:       f3 = 3'b000;
				1:       f3 = 3'b111;
				2:       f3 = 3'b110;
				default: f3 = 3'b100;
			endcase
			add_row($sformatf("mixed_%0d", i), enc_reg(f7, f3, reg_idx_t'(1 + $urandom % 6),
				reg_idx_t'(1 + $urandom % 6), reg_idx_t'(1 + $urandom % 6)),
				int'($urandom % 4));
		end
	endtask

	task automatic check_value(input string name, input logic [37:0] expected,
			input logic [37:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// driver
	//////////////////////////////

	// four-phase req/ack, returns a little after a rising edge
	task automatic send_inst(input inst_t code, input int gap);
		repeat (gap) begin
			@(posedge clock);
			#0.5;
		end
		inst = code;
		inst_req = 1'b1;
		// react on the first edge that shows ack so results can overlap
		do begin
			@(posedge clock);
			#0.5;
		end while (!inst_ack);
		inst_req = 1'b0;
		do begin
			@(posedge clock);
			#0.5;
		end while (inst_ack);
	endtask

	//////////////////////////////
	// monitor and timeout
	//////////////////////////////

	// outputs settle well before the falling edge
	always @(negedge clock) begin
		req_seen = req_seen | inst_req;
		if (!reset && !req_seen && (inst_ack || commit.valid)) begin
			errors++;
			$display("ack or commit went active before the first request");
		end
		if (inst_ack && !ack_prev) begin
			ack_count++;
		end
		ack_prev = inst_ack;
		if (commit.valid) begin
			if (commit_count < num_rows) begin
				err_before = errors;
				check_value(row_name[commit_count], row_expect[commit_count],
					{commit.wr_en, commit.rd, commit.value});
				$display("test %s %s", row_name[commit_count],
					(errors == err_before) ? "ok" : "failed");
			end else begin
				errors++;
				$display("a commit arrived after the whole table had retired");
			end
			commit_count++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d commits seen",
				cycles, commit_count, num_rows);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hb13018ab));
		reset = 1'b1;
		inst_req = 1'b0;
		inst = '0;
		for (int i = 0; i < 32; i++) begin
			gold[i] = '0;
		end
		build_table();
		cycle_limit = num_rows * 20 + 100;
		repeat (10) @(posedge clock);
		#0.5;
		reset = 1'b0;
		// idle stretch, nothing may move yet
		repeat (4) @(posedge clock);
		#0.5;
		for (int i = 0; i < num_rows; i++) begin
			send_inst(row_inst[i], row_gap[i]);
		end
		wait (commit_count >= num_rows);
		repeat (5) @(posedge clock);
		if (ack_count != num_rows) begin
			errors++;
			$display("saw %0d acknowledges for %0d requests", ack_count, num_rows);
		end
		$display("tests %0d, commits %0d, errors %0d", num_rows, commit_count, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/issue_stage.sv
hdl/reorder_buffer.sv
hdl/reservation_station.sv
hdl/alu_unit.sv
hdl/ooo_core.sv
bench/ooo_core_sva.sv
bench/ooo_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module ooo_core_tb -o ooo_core_sim

./obj_dir/ooo_core_sim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
	exit 0
fi
echo "simulation did not pass"
exit 1
